/* dv/core_pc_profiler_tb.sv */
`timescale 1ns/1ps

`include "profile_defs.svh"

module core_pc_profiler_tb
  import pipe_pkg::*;
  import profile_pkg::*;
();

  localparam int N_INSTR        = 200;
  localparam int N_STALL        = 150;
  localparam int N_FP           = 120;
  localparam int N_BUBBLE       = 150;
  localparam int N_SAT          = 300;
  localparam int N_EN           = 100;
  localparam int READ_CYCLES    = `PROF_BIN_COUNT * PROF_OP_COUNT + 3;
  localparam int RUN_CYCLES     = 3 + N_INSTR + N_STALL + N_FP + N_BUBBLE + N_SAT + N_EN
                                  + 7 * READ_CYCLES + 2;
  localparam int TIMEOUT_CYCLES = 4 * RUN_CYCLES;
  localparam int CNT_MAX        = (1 << `PROF_CNT_WIDTH) - 1;

  logic                       clk_i;
  logic                       reset_i;
  logic [`PROF_PC_WIDTH-1:0]  id_pc_i;
  logic [`PROF_PC_WIDTH-1:0]  exe_pc_i;
  logic                       exe_valid_i;
  logic                       fp_exe_valid_i;
  logic                       stall_all_i;
  logic                       stall_id_i;
  logic                       stall_remote_credit_i;
  logic                       stall_remote_req_i;
  logic                       stall_fdiv_busy_i;
  logic                       stall_barrier_i;
  logic                       stall_ifetch_wait_i;
  logic                       stall_depend_load_i;
  logic                       stall_depend_imul_i;
  logic                       flush_i;
  logic                       branch_mispredict_i;
  logic                       jalr_mispredict_i;
  logic                       icache_miss_i;
  logic                       prof_en_i;
  logic                       clear_i;
  logic                       rd_en_i;
  logic [`PROF_BIN_BITS-1:0]  rd_bin_i;
  prof_op_e                   rd_op_i;
  logic                       rd_valid_o;
  logic [`PROF_CNT_WIDTH-1:0] rd_data_o;

  // Reference state
  logic [31:0]               rng_state;
  int                        cycle_cnt;
  int                        model_cnt [`PROF_BIN_COUNT][PROF_OP_COUNT];
  logic [`PROF_PC_WIDTH-1:0] m_fp_pc;
  logic [`PROF_PC_WIDTH-1:0] m_mem_pc;
  exe_bubble_e               m_bub;
  logic [`PROF_PC_WIDTH-1:0] m_bub_pc;
  int                        exp_q [$];
  int                        bin_q [$];
  prof_op_e                  op_q [$];

  core_pc_profiler u_dut (.*);

  always #4 clk_i = ~clk_i;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopping on first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [`PROF_PC_WIDTH-1:0] rand_pc();
    logic [31:0] r;
    r = next_rand();
    return {16'h0, r[15:2], 2'b00};  // Word aligned
  endfunction

  // Class and PC the current cycle is charged to
  function automatic void model_event(output prof_op_e op,
                                      output logic [`PROF_PC_WIDTH-1:0] pc);
    op = op_unknown;
    pc = exe_pc_i;
    if (stall_all_i) begin
      if (stall_remote_credit_i) op = op_stall_remote_credit;
      else if (stall_remote_req_i) op = op_stall_remote_req;
      else if (stall_fdiv_busy_i) op = op_stall_fdiv_busy;
      else if (stall_barrier_i) op = op_stall_barrier;
      else if (stall_ifetch_wait_i) begin
        op = op_stall_ifetch_wait;
        pc = m_mem_pc;
      end
    end else if (exe_valid_i) begin
      op = op_instr;
    end else if (fp_exe_valid_i) begin
      op = op_fp_instr;
      pc = m_fp_pc;
    end else if (stall_depend_load_i || stall_depend_imul_i) begin
      op = stall_depend_load_i ? op_stall_depend_load : op_stall_depend_imul;
      pc = id_pc_i;
    end else if (m_bub == bub_branch_miss || m_bub == bub_jalr_miss ||
                 m_bub == bub_icache_miss) begin
      op = (m_bub == bub_branch_miss) ? op_bubble_branch_miss :
           (m_bub == bub_jalr_miss)   ? op_bubble_jalr_miss : op_bubble_icache_miss;
      pc = m_bub_pc;
    end
  endfunction

  task automatic model_step();
    prof_op_e                  op;
    logic [`PROF_PC_WIDTH-1:0] pc;
    int                        bin;
    model_event(op, pc);
    bin = int'(pc[`PROF_BIN_BITS+1:2]);
    if (clear_i) begin
      foreach (model_cnt[b, o]) model_cnt[b][o] = 0;
    end
    // An event sampled with the clear lands after it
    if (prof_en_i && model_cnt[bin][int'(op)] < CNT_MAX) begin
      model_cnt[bin][int'(op)]++;
    end
    if (!stall_all_i) begin
      if (!stall_id_i) m_fp_pc = id_pc_i;
      if (m_bub == bub_none) m_mem_pc = exe_pc_i;  // Uses bubble state before update
      if (branch_mispredict_i || jalr_mispredict_i) m_bub_pc = exe_pc_i;
      if (branch_mispredict_i) m_bub = bub_branch_miss;
      else if (jalr_mispredict_i) m_bub = bub_jalr_miss;
      else if (icache_miss_i || flush_i) m_bub = bub_icache_miss;
      else if (stall_id_i) m_bub = bub_id_stall;
      else m_bub = bub_none;
    end
  endtask

  task automatic tick();
    model_step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle_inputs();
    {id_pc_i, exe_pc_i} = '0;
    {exe_valid_i, fp_exe_valid_i, stall_all_i, stall_id_i} = '0;
    {stall_remote_credit_i, stall_remote_req_i, stall_fdiv_busy_i} = '0;
    {stall_barrier_i, stall_ifetch_wait_i, stall_depend_load_i, stall_depend_imul_i} = '0;
    {flush_i, branch_mispredict_i, jalr_mispredict_i, icache_miss_i} = '0;
    {prof_en_i, clear_i, rd_en_i} = '0;
    rd_bin_i = '0;
    rd_op_i  = op_instr;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    r = next_rand();
    id_pc_i               = rand_pc();
    exe_pc_i              = rand_pc();
    exe_valid_i           = r[0];
    fp_exe_valid_i        = r[1];
    stall_all_i           = r[2] & r[3];
    stall_id_i            = r[4] & r[5];
    stall_remote_credit_i = r[6];
    stall_remote_req_i    = r[7];
    stall_fdiv_busy_i     = r[8];
    stall_barrier_i       = r[9];
    stall_ifetch_wait_i   = r[10];
    stall_depend_load_i   = r[11];
    stall_depend_imul_i   = r[12];
    flush_i               = r[13] & r[14];
    branch_mispredict_i   = r[15] & r[16];
    jalr_mispredict_i     = r[17] & r[18];
    icache_miss_i         = r[19] & r[20];
  endtask

  // Settle the pipeline, then read every counter back to back
  task automatic readout();
    idle_inputs();
    tick();
    tick();
    for (int b = 0; b < `PROF_BIN_COUNT; b++) begin
      for (int o = 0; o < PROF_OP_COUNT; o++) begin
        rd_en_i  = 1'b1;
        rd_bin_i = b[`PROF_BIN_BITS-1:0];
        rd_op_i  = prof_op_e'(o);
        exp_q.push_back(model_cnt[b][o]);
        bin_q.push_back(b);
        op_q.push_back(prof_op_e'(o));
        tick();
      end
    end
    rd_en_i = 1'b0;
    tick();
  endtask

  task automatic run_phase(input int kind, input int len);
    logic [31:0] r;
    for (int i = 0; i < len; i++) begin
      drive_random();
      r = next_rand();
      prof_en_i = 1'b1;
      case (kind)
        0: begin  // Retired instructions
          stall_all_i = 1'b0;
          exe_valid_i = 1'b1;
        end
        1: begin  // Overlapping stall causes
          stall_all_i = r[0] | r[1];
          if (r[2] & r[3]) begin  // Leave ifetch_wait on top
            stall_remote_credit_i = 1'b0;
            stall_remote_req_i    = 1'b0;
            stall_fdiv_busy_i     = 1'b0;
            stall_barrier_i       = 1'b0;
          end
        end
        2: begin  // FP retire against decode PC
          exe_valid_i = 1'b0;
          stall_all_i = r[0] & r[1] & r[2];
        end
        3: begin  // Mispredict and miss bubbles
          stall_all_i         = 1'b0;
          exe_valid_i         = r[0] & r[1] & r[2];
          fp_exe_valid_i      = 1'b0;
          stall_depend_load_i = 1'b0;
          stall_depend_imul_i = 1'b0;
          branch_mispredict_i = r[3] & r[4];
          jalr_mispredict_i   = r[5] & r[6];
          icache_miss_i       = r[7] & r[8];
        end
        4: begin  // Hammer bin 5, neighbor bin 6 now and then
          stall_all_i = 1'b0;
          exe_valid_i = 1'b1;
          exe_pc_i    = {r[31:6], (i % 9 == 8) ? 4'd6 : 4'd5, 2'b00};
        end
        default: prof_en_i = r[0];  // Gaps in profiling
      endcase
      tick();
    end
    readout();
  endtask

  property rd_valid_follows_rd_en;
    @(posedge clk_i) disable iff (reset_i) rd_valid_o == $past(rd_en_i);
  endproperty

  assert property (rd_valid_follows_rd_en)
    else report_fail($sformatf("MISMATCH t=%0t rd_valid_o expected %0b got %0b",
                               $time, ~$sampled(rd_valid_o), $sampled(rd_valid_o)));

  always @(negedge clk_i) begin : check_read
    int       exp_val;
    int       bin;
    prof_op_e op;
    if (!reset_i && rd_valid_o) begin
      if (exp_q.size() == 0) begin
        report_fail("Read data came back with no read outstanding");
      end else begin
        exp_val = exp_q.pop_front();
        bin     = bin_q.pop_front();
        op      = op_q.pop_front();
        assert (int'(rd_data_o) == exp_val)
          else report_fail($sformatf("MISMATCH t=%0t rd_data_o bin %0d %s expected %0d got %0d",
                                     $time, bin, op.name(), exp_val, rd_data_o));
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_fail("Timeout: the run went past its cycle limit");
    end
  end

  initial begin
    clk_i     = 1'b0;
    reset_i   = 1'b1;
    cycle_cnt = 0;
    rng_state = 32'h5512_3c4f;
    idle_inputs();
    foreach (model_cnt[b, o]) model_cnt[b][o] = 0;
    m_fp_pc  = '0;
    m_mem_pc = '0;
    m_bub    = bub_none;
    m_bub_pc = '0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    run_phase(0, N_INSTR);
    run_phase(1, N_STALL);
    run_phase(2, N_FP);
    run_phase(3, N_BUBBLE);
    run_phase(4, N_SAT);
    run_phase(5, N_EN);
    clear_i = 1'b1;
    tick();
    clear_i = 1'b0;
    readout();  // All zero after clear
    if (exp_q.size() != 0) begin
      report_fail("Some reads never returned data");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* source/core_pc_profiler.sv */
`timescale 1ns/1ps

`include "profile_defs.svh"

module core_pc_profiler
  import pipe_pkg::*;
  import profile_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [`PROF_PC_WIDTH-1:0]  id_pc_i,
  input  logic [`PROF_PC_WIDTH-1:0]  exe_pc_i,
  input  logic                       exe_valid_i,
  input  logic                       fp_exe_valid_i,
  input  logic                       stall_all_i,
  input  logic                       stall_id_i,
  input  logic                       stall_remote_credit_i,
  input  logic                       stall_remote_req_i,
  input  logic                       stall_fdiv_busy_i,
  input  logic                       stall_barrier_i,
  input  logic                       stall_ifetch_wait_i,
  input  logic                       stall_depend_load_i,
  input  logic                       stall_depend_imul_i,
  input  logic                       flush_i,
  input  logic                       branch_mispredict_i,
  input  logic                       jalr_mispredict_i,
  input  logic                       icache_miss_i,
  input  logic                       prof_en_i,
  input  logic                       clear_i,
  input  logic                       rd_en_i,
  input  logic [`PROF_BIN_BITS-1:0]  rd_bin_i,
  input  prof_op_e                   rd_op_i,
  output logic                       rd_valid_o,
  output logic [`PROF_CNT_WIDTH-1:0] rd_data_o
);

  exe_bubble_e               bubble_type;
  logic [`PROF_PC_WIDTH-1:0] bubble_pc;
  logic [`PROF_PC_WIDTH-1:0] fp_exe_pc;
  logic [`PROF_PC_WIDTH-1:0] mem_pc;
  logic                      evt_valid;
  prof_op_e                  evt_op;
  logic [`PROF_PC_WIDTH-1:0] evt_pc;

  pc_tracker u_pc_tracker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .id_pc_i       (id_pc_i),
    .exe_pc_i      (exe_pc_i),
    .stall_all_i   (stall_all_i),
    .stall_id_i    (stall_id_i),
    .bubble_type_i (bubble_type),
    .fp_exe_pc_o   (fp_exe_pc),
    .mem_pc_o      (mem_pc)
  );

  exe_bubble_classifier u_bubble_classifier (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .exe_pc_i            (exe_pc_i),
    .stall_all_i         (stall_all_i),
    .stall_id_i          (stall_id_i),
    .flush_i             (flush_i),
    .branch_mispredict_i (branch_mispredict_i),
    .jalr_mispredict_i   (jalr_mispredict_i),
    .icache_miss_i       (icache_miss_i),
    .bubble_type_o       (bubble_type),
    .bubble_pc_o         (bubble_pc)
  );

  cycle_event_arbiter u_event_arbiter (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .prof_en_i             (prof_en_i),
    .exe_valid_i           (exe_valid_i),
    .fp_exe_valid_i        (fp_exe_valid_i),
    .stall_all_i           (stall_all_i),
    .stall_remote_credit_i (stall_remote_credit_i),
    .stall_remote_req_i    (stall_remote_req_i),
    .stall_fdiv_busy_i     (stall_fdiv_busy_i),
    .stall_barrier_i       (stall_barrier_i),
    .stall_ifetch_wait_i   (stall_ifetch_wait_i),
    .stall_depend_load_i   (stall_depend_load_i),
    .stall_depend_imul_i   (stall_depend_imul_i),
    .id_pc_i               (id_pc_i),
    .exe_pc_i              (exe_pc_i),
    .fp_exe_pc_i           (fp_exe_pc),
    .mem_pc_i              (mem_pc),
    .bubble_type_i         (bubble_type),
    .bubble_pc_i           (bubble_pc),
    .evt_valid_o           (evt_valid),
    .evt_op_o              (evt_op),
    .evt_pc_o              (evt_pc)
  );

  pc_histogram_table u_hist_table (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .clear_i     (clear_i),
    .evt_valid_i (evt_valid),
    .evt_op_i    (evt_op),
    .evt_pc_i    (evt_pc),
    .rd_en_i     (rd_en_i),
    .rd_bin_i    (rd_bin_i),
    .rd_op_i     (rd_op_i),
    .rd_valid_o  (rd_valid_o),
    .rd_data_o   (rd_data_o)
  );

endmodule

/* source/cycle_event_arbiter.sv */
`timescale 1ns/1ps

`include "profile_defs.svh"

module cycle_event_arbiter
  import pipe_pkg::*;
  import profile_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      prof_en_i,
  input  logic                      exe_valid_i,
  input  logic                      fp_exe_valid_i,
  input  logic                      stall_all_i,
  input  logic                      stall_remote_credit_i,
  input  logic                      stall_remote_req_i,
  input  logic                      stall_fdiv_busy_i,
  input  logic                      stall_barrier_i,
  input  logic                      stall_ifetch_wait_i,
  input  logic                      stall_depend_load_i,
  input  logic                      stall_depend_imul_i,
  input  logic [`PROF_PC_WIDTH-1:0] id_pc_i,
  input  logic [`PROF_PC_WIDTH-1:0] exe_pc_i,
  input  logic [`PROF_PC_WIDTH-1:0] fp_exe_pc_i,
  input  logic [`PROF_PC_WIDTH-1:0] mem_pc_i,
  input  exe_bubble_e               bubble_type_i,
  input  logic [`PROF_PC_WIDTH-1:0] bubble_pc_i,
  output logic                      evt_valid_o,
  output prof_op_e                  evt_op_o,
  output logic [`PROF_PC_WIDTH-1:0] evt_pc_o
);

  prof_op_e                  op_n;
  logic [`PROF_PC_WIDTH-1:0] pc_n;

  // First match wins
  always_comb begin
    op_n = op_unknown;
    pc_n = exe_pc_i;
    if (stall_all_i) begin
      if (stall_remote_credit_i) begin
        op_n = op_stall_remote_credit;
      end else if (stall_remote_req_i) begin
        op_n = op_stall_remote_req;
      end else if (stall_fdiv_busy_i) begin
        op_n = op_stall_fdiv_busy;
      end else if (stall_barrier_i) begin
        op_n = op_stall_barrier;
      end else if (stall_ifetch_wait_i) begin
        op_n = op_stall_ifetch_wait;
        pc_n = mem_pc_i;  // Writeback waiting in memory stage
      end
    end else if (exe_valid_i) begin
      op_n = op_instr;
    end else if (fp_exe_valid_i) begin
      op_n = op_fp_instr;
      pc_n = fp_exe_pc_i;
    end else if (stall_depend_load_i) begin
      op_n = op_stall_depend_load;
      pc_n = id_pc_i;  // Stuck consumer in decode
    end else if (stall_depend_imul_i) begin
      op_n = op_stall_depend_imul;
      pc_n = id_pc_i;
    end else begin
      case (bubble_type_i)
        bub_branch_miss: op_n = op_bubble_branch_miss;
        bub_jalr_miss:   op_n = op_bubble_jalr_miss;
        bub_icache_miss: op_n = op_bubble_icache_miss;
        default:         op_n = op_unknown;
      endcase
      if (op_n != op_unknown) begin
        pc_n = bubble_pc_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      evt_valid_o <= 1'b0;
    end else begin
      evt_valid_o <= prof_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    evt_op_o <= op_n;
    evt_pc_o <= pc_n;
  end

endmodule

/* source/exe_bubble_classifier.sv */
`timescale 1ns/1ps

`include "profile_defs.svh"

module exe_bubble_classifier
  import pipe_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [`PROF_PC_WIDTH-1:0] exe_pc_i,
  input  logic                      stall_all_i,
  input  logic                      stall_id_i,
  input  logic                      flush_i,
  input  logic                      branch_mispredict_i,
  input  logic                      jalr_mispredict_i,
  input  logic                      icache_miss_i,
  output exe_bubble_e               bubble_type_o,
  output logic [`PROF_PC_WIDTH-1:0] bubble_pc_o
);

  exe_bubble_e               bubble_type_r;
  exe_bubble_e               bubble_type_n;
  logic [`PROF_PC_WIDTH-1:0] bubble_pc_r;
  logic [`PROF_PC_WIDTH-1:0] bubble_pc_n;

  // Cause of the bubble that enters execute next cycle
  always_comb begin
    bubble_type_n = bub_none;
    bubble_pc_n   = bubble_pc_r;  // Hold unless a mispredict
    if (branch_mispredict_i) begin
      bubble_type_n = bub_branch_miss;
      bubble_pc_n   = exe_pc_i;  // Offending branch
    end else if (jalr_mispredict_i) begin
      bubble_type_n = bub_jalr_miss;
      bubble_pc_n   = exe_pc_i;
    end else if (icache_miss_i || flush_i) begin
      bubble_type_n = bub_icache_miss;
    end else if (stall_id_i) begin
      bubble_type_n = bub_id_stall;
    end
  end

  // A full-pipe stall freezes the execute stage contents
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bubble_type_r <= bub_none;
    end else if (!stall_all_i) begin
      bubble_type_r <= bubble_type_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bubble_pc_r <= '0;
    end else if (!stall_all_i) begin
      bubble_pc_r <= bubble_pc_n;
    end
  end

  assign bubble_type_o = bubble_type_r;
  assign bubble_pc_o   = bubble_pc_r;

endmodule

/* source/pc_histogram_table.sv */
`timescale 1ns/1ps

`include "profile_defs.svh"

module pc_histogram_table
  import profile_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       clear_i,
  input  logic                       evt_valid_i,
  input  prof_op_e                   evt_op_i,
  input  logic [`PROF_PC_WIDTH-1:0]  evt_pc_i,
  input  logic                       rd_en_i,
  input  logic [`PROF_BIN_BITS-1:0]  rd_bin_i,
  input  prof_op_e                   rd_op_i,
  output logic                       rd_valid_o,
  output logic [`PROF_CNT_WIDTH-1:0] rd_data_o
);

  logic [`PROF_CNT_WIDTH-1:0] cnt_r [`PROF_BIN_COUNT][PROF_OP_COUNT];
  logic [`PROF_BIN_BITS-1:0]  evt_bin;
  logic [`PROF_BIN_COUNT-1:0] bin_hit;
  logic [PROF_OP_COUNT-1:0]   op_hit;
  logic [`PROF_CNT_WIDTH-1:0] rd_sel;

  assign evt_bin = evt_pc_i[`PROF_BIN_BITS+1:2];  // Word address bits

  // One-hot row and column of the counter to bump
  always_comb begin
    bin_hit          = '0;
    bin_hit[evt_bin] = evt_valid_i;
  end

  always_comb begin
    op_hit = '0;
    if (evt_op_i < PROF_OP_COUNT) begin
      op_hit[evt_op_i] = 1'b1;
    end
  end

  // Counters stick at all ones
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `PROF_BIN_COUNT; b++) begin
      for (int o = 0; o < PROF_OP_COUNT; o++) begin
        if (reset_i || clear_i) begin
          cnt_r[b][o] <= '0;
        end else if (bin_hit[b] && op_hit[o] &&
                     (cnt_r[b][o] != {`PROF_CNT_WIDTH{1'b1}})) begin
          cnt_r[b][o] <= cnt_r[b][o] + 1'b1;
        end
      end
    end
  end

  // Unused encodings read as zero
  always_comb begin
    rd_sel = '0;
    if (rd_op_i < PROF_OP_COUNT) begin
      rd_sel = cnt_r[rd_bin_i][rd_op_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_en_i;
    end
  end

  // Sees counter state before a same-edge update
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= rd_sel;
    end
  end

endmodule

/* source/pc_tracker.sv */
`timescale 1ns/1ps

`include "profile_defs.svh"

module pc_tracker
  import pipe_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [`PROF_PC_WIDTH-1:0] id_pc_i,
  input  logic [`PROF_PC_WIDTH-1:0] exe_pc_i,
  input  logic                      stall_all_i,
  input  logic                      stall_id_i,
  input  exe_bubble_e               bubble_type_i,
  output logic [`PROF_PC_WIDTH-1:0] fp_exe_pc_o,
  output logic [`PROF_PC_WIDTH-1:0] mem_pc_o
);

  logic id_advance;
  logic exe_advance;

  assign id_advance  = !stall_all_i && !stall_id_i;  // Instr leaves decode
  assign exe_advance = !stall_all_i && (bubble_type_i == bub_none);

  // FP and imul results are charged to the PC that left decode
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fp_exe_pc_o <= '0;
    end else if (id_advance) begin
      fp_exe_pc_o <= id_pc_i;
    end
  end

  // Memory stage only follows real instructions
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_pc_o <= '0;
    end else if (exe_advance) begin
      mem_pc_o <= exe_pc_i;
    end
  end

endmodule

/* source/pipe_pkg.sv */
package pipe_pkg;

  // Why the execute stage holds a bubble
  typedef enum logic [2:0] {
    bub_none        = 3'd0,
    bub_branch_miss = 3'd1,  // Branch mispredict recovery
    bub_jalr_miss   = 3'd2,  // Jalr target mispredict
    bub_icache_miss = 3'd3,  // Also covers flushes
    bub_id_stall    = 3'd4   // Decode held, nothing issued
  } exe_bubble_e;

endpackage

/* source/profile_defs.svh */
`ifndef PROFILE_DEFS_SVH
`define PROFILE_DEFS_SVH

// PC ports of the core
`define PROF_PC_WIDTH 32

// Bin index is PC[5:2]
`define PROF_BIN_BITS 4
`define PROF_BIN_COUNT (1 << `PROF_BIN_BITS)

// Saturating counters
`define PROF_CNT_WIDTH 8

`endif

/* source/profile_pkg.sv */
package profile_pkg;

  // Operation class a cycle is charged to
  typedef enum logic [3:0] {
    op_instr               = 4'd0,
    op_fp_instr            = 4'd1,
    op_stall_remote_credit = 4'd2,
    op_stall_remote_req    = 4'd3,
    op_stall_fdiv_busy     = 4'd4,
    op_stall_barrier       = 4'd5,
    op_stall_ifetch_wait   = 4'd6,
    op_stall_depend_load   = 4'd7,
    op_stall_depend_imul   = 4'd8,
    op_bubble_branch_miss  = 4'd9,
    op_bubble_jalr_miss    = 4'd10,
    op_bubble_icache_miss  = 4'd11,
    op_unknown             = 4'd12
  } prof_op_e;

  localparam int PROF_OP_COUNT = 13;  // Table columns

endpackage

/* verilog.f */
+incdir+source
source/pipe_pkg.sv
source/profile_pkg.sv
source/pc_tracker.sv
source/exe_bubble_classifier.sv
source/cycle_event_arbiter.sv
source/pc_histogram_table.sv
source/core_pc_profiler.sv
dv/core_pc_profiler_tb.sv
